//--- design/div_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divide unit package
// Operation codes and the request, prepared-operand
// and response structs of the divide datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package div_pkg;

    localparam int xlen = 32;  // One data word

    // RISC-V M-extension divide and remainder operations
    typedef enum logic [1:0] {
        op_div  = 2'b00,
        op_divu = 2'b01,
        op_rem  = 2'b10,
        op_remu = 2'b11
    } div_op_t;

    typedef struct packed {
        div_op_t         op;
        logic [xlen-1:0] a;       // Dividend
        logic [xlen-1:0] b;       // Divisor
    } div_req_t;

    typedef struct packed {
        logic [xlen-1:0] a_mag;   // Unsigned dividend magnitude
        logic [xlen-1:0] b_mag;   // Unsigned divisor magnitude
        logic            sel_rem; // Remainder wanted
        logic            neg_q;   // Negate quotient
        logic            neg_r;   // Negate remainder
        logic            b_zero;  // Divisor is zero
        logic [xlen-1:0] a_orig;  // Dividend as written
    } div_prep_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic            div_by_zero;
    } div_rsp_t;

endpackage

`default_nettype wire

//--- design/wb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic package
// Bus request and response structs and the
// register map of the divide unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package wb_pkg;

    localparam int dw = 32;  // Bus data width

    typedef struct packed {
        logic          cyc;
        logic          stb;
        logic          we;
        logic [7:0]    adr;
        logic [dw-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic          ack;
        logic [dw-1:0] dat;
    } wb_rsp_t;

    // Register map in byte addresses
    localparam logic [7:0] reg_opa    = 8'h00;
    localparam logic [7:0] reg_opb    = 8'h04;
    localparam logic [7:0] reg_ctrl   = 8'h08;
    localparam logic [7:0] reg_result = 8'h0C;
    localparam logic [7:0] reg_status = 8'h10;

endpackage

`default_nettype wire

//--- design/div_radix8.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Radix-8 restoring divider
// Unsigned, three quotient bits per cycle, finishes
// at once when the divisor exceeds the dividend
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module div_radix8 #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             ack,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] q,
    output logic [WIDTH-1:0] r,
    output logic             complete
);

    localparam int DIGITS = (WIDTH + 2) / 3;    // Radix-8 digits per operand
    localparam int QW     = 3 * DIGITS;         // Dividend padded to whole digits
    localparam int CW     = $clog2(DIGITS) + 1;

    logic [QW-1:0]    a_ext;
    logic [WIDTH+3:0] b_ext;
    logic             early;      // Divisor greater than dividend
    logic             iterate;
    logic [CW-1:0]    cnt;        // Digits still to retire

    logic [WIDTH+2:0] pr;         // Partial remainder with next dividend digit
    logic [QW-1:0]    qd;         // Dividend bits left, quotient digits shifted in
    logic [WIDTH+2:0] pr_in;
    logic [QW-1:0]    qd_in;

    logic [WIDTH+3:0] mult;
    logic [WIDTH+3:0] diff;
    logic [2:0]       digit;
    logic [WIDTH-1:0] rem;

    assign a_ext   = QW'(a);
    assign b_ext   = {4'b0000, b};
    assign early   = b > a;
    assign iterate = (start && !early) || cnt != '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Digit selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The first digit is taken straight from the operands on start
    always_comb begin
        if (start) begin
            pr_in = {{WIDTH{1'b0}}, a_ext[QW-1:QW-3]};
            qd_in = {a_ext[QW-4:0], 3'b000};
        end else begin
            pr_in = pr;
            qd_in = qd;
        end
    end

    // Largest multiple of b not above the partial remainder
    always_comb begin
        digit = 3'd0;
        rem   = pr_in[WIDTH-1:0];
        mult  = '0;
        diff  = '0;
        for (int k = 1; k < 8; k++) begin
            mult = mult + b_ext;
            diff = {1'b0, pr_in} - mult;
            if (!diff[WIDTH+3]) begin   // Non-negative difference
                digit = 3'(k);
                rem   = diff[WIDTH-1:0];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Iteration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (start && early) begin
            pr <= {a, 3'b000};                          // Remainder is a, quotient zero
            qd <= '0;
        end else if (iterate) begin
            pr <= {rem, qd_in[QW-1:QW-3]};              // Bring down next digit
            qd <= {qd_in[QW-4:0], digit};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            complete <= 1'b0;
        end else if (start) begin
            cnt      <= early ? '0 : CW'(DIGITS - 1);  // First digit done this cycle
            complete <= early;
        end else if (cnt != '0) begin
            cnt      <= cnt - 1'b1;
            complete <= cnt == CW'(1);                 // Last digit retires now
        end else if (ack) begin
            complete <= 1'b0;
        end
    end

    assign q = qd[WIDTH-1:0];
    assign r = pr[WIDTH+2:3];

endmodule

`default_nettype wire

//--- design/div_operand_prep.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand preparation stage
// Strips operand signs and records the fix-up flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module div_operand_prep (
    input  logic                clk,
    input  logic                en,
    input  div_pkg::div_req_t   req,
    output div_pkg::div_prep_t  prep
);

    logic is_signed;
    logic a_neg;
    logic b_neg;

    assign is_signed = req.op == div_pkg::op_div || req.op == div_pkg::op_rem;
    assign a_neg     = is_signed & req.a[div_pkg::xlen-1];
    assign b_neg     = is_signed & req.b[div_pkg::xlen-1];

    always_ff @(posedge clk) begin
        if (en) begin
            prep.a_mag   <= a_neg ? -req.a : req.a;    // Most negative stays 2**31
            prep.b_mag   <= b_neg ? -req.b : req.b;
            prep.sel_rem <= req.op == div_pkg::op_rem || req.op == div_pkg::op_remu;
            prep.neg_q   <= a_neg ^ b_neg;
            prep.neg_r   <= a_neg;                     // Remainder takes dividend sign
            prep.b_zero  <= req.b == '0;
            prep.a_orig  <= req.a;
        end
    end

endmodule

`default_nettype wire

//--- design/div_result_fix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result fix-up stage
// Picks quotient or remainder, restores the sign
// and applies the divide-by-zero rule
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module div_result_fix (
    input  logic                      clk,
    input  logic                      en,
    input  div_pkg::div_prep_t        prep,
    input  logic [div_pkg::xlen-1:0]  q,
    input  logic [div_pkg::xlen-1:0]  r,
    output div_pkg::div_rsp_t         rsp
);

    logic [div_pkg::xlen-1:0] mag;
    logic                     neg;
    logic [div_pkg::xlen-1:0] signed_res;
    logic [div_pkg::xlen-1:0] zero_res;

    assign mag        = prep.sel_rem ? r : q;
    assign neg        = prep.sel_rem ? prep.neg_r : prep.neg_q;
    assign signed_res = neg ? -mag : mag;

    // Divide by zero gives all ones as quotient and the dividend as remainder
    assign zero_res   = prep.sel_rem ? prep.a_orig : '1;

    // Overflow needs no special path.
    // 2**31 / 1 with equal signs comes out as the dividend, remainder zero.
    always_ff @(posedge clk) begin
        if (en) begin
            rsp.result      <= prep.b_zero ? zero_res : signed_res;
            rsp.div_by_zero <= prep.b_zero;
        end
    end

endmodule

`default_nettype wire

//--- design/div_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divide control FSM
// Sequences preparation, core run, fix-up and done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module div_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic done,
    output logic prep_en,
    output logic core_start,
    output logic core_ack,
    output logic fix_en,
    input  logic core_complete
);

    typedef enum logic [2:0] {
        idle,
        prep,
        run,
        fix,
        done_st
    } state_t;

    state_t state_q;
    state_t state_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State register and next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
            done    <= 1'b0;
        end else begin
            state_q <= state_d;
            done    <= state_q == done_st;  // Pulse on the way back to idle
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle:    if (start) state_d = prep;
            prep:    state_d = run;
            run:     if (core_complete) state_d = fix;
            fix:     state_d = done_st;
            done_st: state_d = idle;
            default: state_d = idle;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign busy       = state_q != idle;
    assign prep_en    = state_q == idle && start;           // Operands held in registers
    assign core_start = state_q == prep;                    // Prepared operands valid now
    assign core_ack   = state_q == run && core_complete;    // Same cycle as move to fix
    assign fix_en     = state_q == fix;                     // Core outputs still held

endmodule

`default_nettype wire

//--- design/div_wb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divide unit register slave
// Wishbone classic access to operands, control,
// result and status, with busy stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module div_wb_regs (
    input  logic               clk,
    input  logic               rst,
    input  wb_pkg::wb_req_t    wb_req,
    output wb_pkg::wb_rsp_t    wb_rsp,
    output logic               start,
    output div_pkg::div_req_t  req,
    input  logic               busy,
    input  logic               done,
    input  div_pkg::div_rsp_t  rsp
);

    logic                     ack_q;
    logic [wb_pkg::dw-1:0]    rdata_q;
    div_pkg::div_req_t        req_q;
    logic [div_pkg::xlen-1:0] result_q;
    logic                     dbz_q;        // Divide by zero of last result

    logic                     busy_any;
    logic                     access;
    logic                     stall;
    logic                     accept;
    logic [div_pkg::xlen-1:0] result_next;
    logic                     dbz_next;

    assign busy_any = busy | start;         // Start pulse precedes FSM busy
    assign access   = wb_req.cyc & wb_req.stb & ~ack_q;
    assign stall    = busy_any & (wb_req.we | wb_req.adr == wb_pkg::reg_result);
    assign accept   = access & ~stall;

    // A response landing this cycle is returned at once
    assign result_next = done ? rsp.result : result_q;
    assign dbz_next    = done ? rsp.div_by_zero : dbz_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control and status
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            start <= 1'b0;
            dbz_q <= 1'b0;
        end else begin
            ack_q <= accept;
            start <= accept & wb_req.we & wb_req.adr == wb_pkg::reg_ctrl;
            dbz_q <= dbz_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        result_q <= result_next;
        if (accept && wb_req.we) begin
            case (wb_req.adr)
                wb_pkg::reg_opa:  req_q.a  <= wb_req.dat;
                wb_pkg::reg_opb:  req_q.b  <= wb_req.dat;
                wb_pkg::reg_ctrl: req_q.op <= div_pkg::div_op_t'(wb_req.dat[1:0]);
                default:          ;
            endcase
        end
        if (accept && !wb_req.we) begin
            case (wb_req.adr)
                wb_pkg::reg_opa:    rdata_q <= req_q.a;
                wb_pkg::reg_opb:    rdata_q <= req_q.b;
                wb_pkg::reg_ctrl:   rdata_q <= {{(wb_pkg::dw-2){1'b0}}, req_q.op};
                wb_pkg::reg_result: rdata_q <= result_next;
                wb_pkg::reg_status: rdata_q <= {{(wb_pkg::dw-2){1'b0}}, dbz_next, busy_any};
                default:            rdata_q <= '0;
            endcase
        end
    end

    assign req        = req_q;
    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdata_q;

endmodule

`default_nettype wire

//--- design/div_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divide unit top level
// Register slave, control FSM and the three datapath stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module div_top (
    input  logic             clk,
    input  logic             rst,
    input  wb_pkg::wb_req_t  wb_req,
    output wb_pkg::wb_rsp_t  wb_rsp
);

    logic                     start;
    div_pkg::div_req_t        req;
    logic                     busy;
    logic                     done;
    div_pkg::div_rsp_t        rsp;

    logic                     prep_en;
    logic                     core_start;
    logic                     core_ack;
    logic                     core_complete;
    logic                     fix_en;
    div_pkg::div_prep_t       prep;
    logic [div_pkg::xlen-1:0] core_q;
    logic [div_pkg::xlen-1:0] core_r;

    div_wb_regs i_regs (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .rsp    (rsp)
    );

    div_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .prep_en       (prep_en),
        .core_start    (core_start),
        .core_ack      (core_ack),
        .fix_en        (fix_en),
        .core_complete (core_complete)
    );

    div_operand_prep i_prep (
        .clk  (clk),
        .en   (prep_en),
        .req  (req),
        .prep (prep)
    );

    div_radix8 #(
        .WIDTH (div_pkg::xlen)
    ) i_core (
        .clk      (clk),
        .rst      (rst),
        .start    (core_start),
        .ack      (core_ack),
        .a        (prep.a_mag),   // Magnitudes only, signs restored later
        .b        (prep.b_mag),
        .q        (core_q),
        .r        (core_r),
        .complete (core_complete)
    );

    div_result_fix i_fix (
        .clk  (clk),
        .en   (fix_en),
        .prep (prep),
        .q    (core_q),
        .r    (core_r),
        .rsp  (rsp)
    );

endmodule

`default_nettype wire

//--- testbench/div_tb_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divide unit protocol checker
// Assertions on the Wishbone and core handshakes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module div_tb_chk (
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::wb_req_t wb_req,
    input  wb_pkg::wb_rsp_t wb_rsp,
    input  logic            prep_en,
    input  logic            core_start,
    input  logic            core_ack,
    input  logic            core_complete
);

    timeunit 1ns;
    timeprecision 100ps;

    ack_with_request: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
        else $error("ack seen without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack high two cycles in a row");

    // Core starts only after control leaves idle and with the core released
    core_start_after_idle: assert property (@(posedge clk) disable iff (rst)
        core_start |-> $past(prep_en) && !core_complete)
        else $error("core_start without a start from idle or while the core still completes");

    core_released_after_ack: assert property (@(posedge clk) disable iff (rst)
        core_ack |=> !core_complete)
        else $error("core_complete still high in the cycle after core_ack");

    ack_low_after_reset: assert property (@(posedge clk)
        rst |=> !wb_rsp.ack)
        else $error("ack high in the cycle after reset");

endmodule

`default_nettype wire

//--- testbench/div_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divide unit testbench
// Drives the Wishbone slave through random, corner-case
// and stall scenarios and checks against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module div_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_ops    = 300;
    localparam int op_cycles  = 40;
    localparam int max_cycles = num_ops * op_cycles;   // Whole-run limit
    localparam int ack_limit  = 64;                    // Longest wait for one access
    localparam int n_rand     = 100;                   // Random operations per group
    localparam logic [div_pkg::xlen-1:0] int_min = 32'h8000_0000;

    logic            clk;
    logic            rst;
    wb_pkg::wb_req_t wb_req;
    wb_pkg::wb_rsp_t wb_rsp;
    int              cycle_cnt;

    div_top i_dut (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    bind div_top div_tb_chk i_chk (
        .clk           (clk),
        .rst           (rst),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .prep_en       (prep_en),
        .core_start    (core_start),
        .core_ack      (core_ack),
        .core_complete (core_complete)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            report_failure("Timeout, the run did not finish within the cycle limit");
        end
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic div_pkg::div_rsp_t div_model(input div_pkg::div_op_t op,
                                                    input logic [div_pkg::xlen-1:0] a,
                                                    input logic [div_pkg::xlen-1:0] b);
        div_pkg::div_rsp_t              exp;
        logic                           is_signed;
        logic                           want_rem;
        logic [div_pkg::xlen-1:0]       q;
        logic [div_pkg::xlen-1:0]       r;
        is_signed = op == div_pkg::op_div || op == div_pkg::op_rem;
        want_rem  = op == div_pkg::op_rem || op == div_pkg::op_remu;
        if (b == '0) begin
            q = '1;                                     // RISC-V divide by zero
            r = a;
        end else if (is_signed && a == int_min && b == '1) begin
            q = a;                                      // Signed overflow
            r = '0;
        end else if (is_signed) begin
            q = $signed(a) / $signed(b);                // Truncates toward zero
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        exp.result      = want_rem ? r : q;
        exp.div_by_zero = b == '0;
        return exp;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus access and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One classic cycle with ack and data sampled on the falling edge
    task automatic bus_access(input logic we, input logic [7:0] adr,
                              input logic [wb_pkg::dw-1:0] wdat,
                              output logic [wb_pkg::dw-1:0] rdat, output int waited);
        wb_pkg::wb_req_t r;
        r.cyc  = 1'b1;
        r.stb  = 1'b1;
        r.we   = we;
        r.adr  = adr;
        r.dat  = wdat;
        waited = 0;
        @(posedge clk);
        wb_req <= r;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ack_limit) begin
                report_failure($sformatf("No ack for access to address 0x%02h", adr));
            end
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;                                   // Strobe low for at least a cycle
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [wb_pkg::dw-1:0] wdat);
        logic [wb_pkg::dw-1:0] unused;
        int                    waited;
        bus_access(1'b1, adr, wdat, unused, waited);
    endtask

    task automatic bus_read(input logic [7:0] adr, output logic [wb_pkg::dw-1:0] rdat,
                            output int waited);
        bus_access(1'b0, adr, '0, rdat, waited);
    endtask

    task automatic check_result(input logic [wb_pkg::dw-1:0] got, input div_pkg::div_rsp_t exp,
                                input div_pkg::div_op_t op, input logic [31:0] a,
                                input logic [31:0] b);
        if (got !== exp.result) begin
            report_failure($sformatf(
                "Mismatch reg_result: got 0x%08h expected 0x%08h (%s a 0x%08h b 0x%08h)",
                got, exp.result, op.name(), a, b));
        end
    endtask

    task automatic check_status(input logic [wb_pkg::dw-1:0] got, input logic exp_busy,
                                input logic exp_dbz);
        logic [wb_pkg::dw-1:0] exp;
        exp = {{(wb_pkg::dw-2){1'b0}}, exp_dbz, exp_busy};
        if (got !== exp) begin
            report_failure($sformatf("Mismatch reg_status: got 0x%08h expected 0x%08h",
                                     got, exp));
        end
    endtask

    // Full operation with operands, start, result read and idle status check
    task automatic run_op(input div_pkg::div_op_t op, input logic [31:0] a,
                          input logic [31:0] b);
        div_pkg::div_rsp_t     exp;
        logic [wb_pkg::dw-1:0] rdat;
        int                    waited;
        exp = div_model(op, a, b);
        bus_write(wb_pkg::reg_opa, a);
        bus_write(wb_pkg::reg_opb, b);
        bus_write(wb_pkg::reg_ctrl, {30'b0, op});
        bus_read(wb_pkg::reg_result, rdat, waited);
        check_result(rdat, exp, op, a, b);
        bus_read(wb_pkg::reg_status, rdat, waited);
        check_status(rdat, 1'b0, exp.div_by_zero);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] a_mag;
        logic [31:0] b_mag;
        logic [31:0] rdat;
        int          waited;
        void'($urandom(32'hed2494c6));
        clk       = 1'b0;
        rst       = 1'b1;
        wb_req    = '0;
        cycle_cnt = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        bus_read(wb_pkg::reg_status, rdat, waited);     // Clean state after reset
        check_status(rdat, 1'b0, 1'b0);

        // Status and result read straight after the start
        bus_write(wb_pkg::reg_opa, 32'hFFFF_FFF0);
        bus_write(wb_pkg::reg_opb, 32'd3);
        bus_write(wb_pkg::reg_ctrl, {30'b0, div_pkg::op_divu});
        bus_read(wb_pkg::reg_status, rdat, waited);
        check_status(rdat, 1'b1, 1'b0);
        bus_read(wb_pkg::reg_result, rdat, waited);
        if (waited <= 2) begin
            report_failure("Result read right after the start was not stalled");
        end
        check_result(rdat, div_model(div_pkg::op_divu, 32'hFFFF_FFF0, 32'd3),
                     div_pkg::op_divu, 32'hFFFF_FFF0, 32'd3);
        bus_read(wb_pkg::reg_status, rdat, waited);
        check_status(rdat, 1'b0, 1'b0);

        for (int i = 0; i < n_rand; i++) begin          // Unsigned with small and large divisors
            a = $urandom >> ($urandom % 32);
            b = $urandom >> ($urandom % 32);
            run_op(i[0] ? div_pkg::op_remu : div_pkg::op_divu, a, b);
        end

        for (int i = 0; i < n_rand; i++) begin          // Signed with the sign pair from i[2:1]
            a_mag = ($urandom >> 1) >> ($urandom % 31);
            b_mag = ($urandom >> 1) >> ($urandom % 31);
            a     = i[1] ? -a_mag : a_mag;
            b     = i[2] ? -b_mag : b_mag;
            run_op(i[0] ? div_pkg::op_rem : div_pkg::op_div, a, b);
        end

        for (int k = 0; k < 4; k++) begin               // Divide by zero for all operations
            run_op(div_pkg::div_op_t'(k), 32'h8765_4321, 32'd0);
        end
        run_op(div_pkg::op_divu, 32'd100, 32'd7);       // Clears the flag again

        run_op(div_pkg::op_div, int_min, 32'hFFFF_FFFF);
        run_op(div_pkg::op_rem, int_min, 32'hFFFF_FFFF);
        run_op(div_pkg::op_divu, int_min, 32'hFFFF_FFFF);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/div_pkg.sv
design/wb_pkg.sv
design/div_radix8.sv
design/div_operand_prep.sv
design/div_result_fix.sv
design/div_ctrl.sv
design/div_wb_regs.sv
design/div_top.sv
testbench/div_tb_chk.sv
testbench/div_tb.sv

//--- Bender.yml
package:
  name: div_unit

sources:
  - files:
      - design/div_pkg.sv
      - design/wb_pkg.sv
      - design/div_radix8.sv
      - design/div_operand_prep.sv
      - design/div_result_fix.sv
      - design/div_ctrl.sv
      - design/div_wb_regs.sv
      - design/div_top.sv
  - target: test
    files:
      - testbench/div_tb_chk.sv
      - testbench/div_tb.sv
